// File: logic/sauria_seq_config.svh
// ===================================================================
// Configuration sequencer parameters
// Register counts per accelerator configuration region
// Region base offsets and fixed register offsets
// Launch word bit positions
// ===================================================================

`ifndef SAURIA_SEQ_CONFIG_SVH
`define SAURIA_SEQ_CONFIG_SVH

// Registers per region
`define SEQ_REGS_CON 4
`define SEQ_REGS_ACT 3
`define SEQ_REGS_WEI 3
`define SEQ_REGS_OUT 2
`define SEQ_N_CFG_REGS (`SEQ_REGS_CON + `SEQ_REGS_ACT + `SEQ_REGS_WEI + `SEQ_REGS_OUT)

// Region bases in the accelerator register map
`define SEQ_CON_BASE 13'h0010
`define SEQ_ACT_BASE 13'h0040
`define SEQ_WEI_BASE 13'h0080
`define SEQ_OUT_BASE 13'h00C0

`define SEQ_CTRL_OFFSET        13'h0000
`define SEQ_INTR_EN_OFFSET     13'h0004
`define SEQ_INTR_STATUS_OFFSET 13'h000C

// Launch word fields
`define SEQ_START_BIT  0
`define SEQ_ENABLE_BIT 1
`define SEQ_SWAP_BIT   16
`define SEQ_KEEP_A_BIT 17
`define SEQ_KEEP_B_BIT 18
`define SEQ_KEEP_C_BIT 19

`endif

// File: logic/sauria_seq_pkg.sv
// ===================================================================
// Shared types of the configuration sequencer
// Width typedefs, command and AXI4-Lite write structs
// Mode struct, region and sequence state enums
// ===================================================================

`include "sauria_seq_config.svh"

package sauria_seq_pkg;

    localparam int ADDR_W = 13;
    localparam int DATA_W = 32;
    // Enough to count every config write plus the interrupt block
    localparam int IDX_W  = $clog2(`SEQ_N_CFG_REGS + 4);

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;

    typedef struct packed {
        logic no_start;
        logic keep_a;
        logic keep_b;
        logic keep_c;
    } seq_mode_t;

    typedef struct packed {
        logic      issue;
        reg_addr_t addr;
        word_t     data;
    } wr_cmd_t;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        word_t       wdata;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axil_wr_rsp_t;

    typedef enum logic [2:0] {
        MAIN,
        ACT,
        WEI,
        OUT,
        INTR
    } cfg_region_e;

    typedef enum logic [3:0] {
        IDLE,
        WALK,
        SYNC_RESP,
        LAUNCH,
        LAUNCH_RESP,
        WAIT_IRQ,
        CLEAR,
        CLEAR_RESP,
        DONE
    } seq_state_e;

endpackage

// File: logic/axil_write_port.sv
// ===================================================================
// AXI4-Lite write port
// One write in flight on the AW/W channels at a time
// Address and data handshakes complete independently
// Counter of write responses still outstanding on B
// ===================================================================

`timescale 1ns/1ps

module axil_write_port (
    input  logic                         clk,
    input  logic                         rst,
    input  sauria_seq_pkg::wr_cmd_t      cmd,
    input  sauria_seq_pkg::axil_wr_rsp_t rsp,
    output sauria_seq_pkg::axil_wr_req_t req,
    output logic                         wr_accepted,
    output logic                         resp_idle
);

    import sauria_seq_pkg::*;

    logic      busy;
    logic      addr_sent;
    logic      data_sent;
    logic      aw_done;
    logic      w_done;
    reg_addr_t addr_q;
    word_t     data_q;
    reg_idx_t  outstanding;

    always_comb begin
        req.awvalid = busy && !addr_sent;
        req.awaddr  = 32'(addr_q);
        req.wvalid  = busy && !data_sent;
        req.wdata   = data_q;
        // Responses are always taken
        req.bready  = 1'b1;
    end

    // Each channel is done once its handshake happened, now or earlier
    assign aw_done     = addr_sent || (req.awvalid && rsp.awready);
    assign w_done      = data_sent || (req.wvalid && rsp.wready);
    assign wr_accepted = busy && aw_done && w_done;
    assign resp_idle   = (outstanding == '0);

    always_ff @(posedge clk) begin
        if (cmd.issue) begin
            addr_q <= cmd.addr;
            data_q <= cmd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            addr_sent <= 1'b0;
            data_sent <= 1'b0;
        end else if (cmd.issue) begin
            busy      <= 1'b1;
            addr_sent <= 1'b0;
            data_sent <= 1'b0;
        end else if (wr_accepted) begin
            busy      <= 1'b0;
            addr_sent <= 1'b0;
            data_sent <= 1'b0;
        end else begin
            addr_sent <= aw_done;
            data_sent <= w_done;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            case ({wr_accepted, rsp.bvalid && req.bready})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // The command source must wait for the previous acceptance
    a_no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
        cmd.issue |-> !busy)
        else $error("write command issued while port busy");

    // Target must not answer a write that was never accepted
    a_no_resp_underflow: assert property (@(posedge clk) disable iff (rst)
        rsp.bvalid |-> (outstanding != '0))
        else $error("write response without outstanding write");

endmodule

// File: logic/cfg_write_walker.sv
// ===================================================================
// Configuration write walker
// Steps through the main, activation, weight and partial-sum regions
// followed by the interrupt-enable block
// One write command per accepted write
// ===================================================================

`timescale 1ns/1ps

`include "sauria_seq_config.svh"

module cfg_write_walker (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          walk_start,
    input  logic                                          wr_accepted,
    input  sauria_seq_pkg::word_t [`SEQ_N_CFG_REGS-1:0] cfg_words,
    output sauria_seq_pkg::wr_cmd_t                       cfg_cmd,
    output logic                                          walk_done
);

    import sauria_seq_pkg::*;

    cfg_region_e                    region;
    reg_addr_t                      addr;
    reg_idx_t                       count;
    reg_idx_t                       idx;
    logic                           active;
    logic                           issue_q;
    logic                           last_write;
    word_t [`SEQ_N_CFG_REGS-1:0]   words_q;

    assign last_write = (region == INTR) && (count == '0);
    assign walk_done  = active && wr_accepted && last_write;

    always_comb begin
        cfg_cmd.issue = issue_q;
        cfg_cmd.addr  = addr;
        // Interrupt block: enables at 0x4 and 0x8, status cleared at 0xC
        if (region == INTR) begin
            cfg_cmd.data = (count != '0) ? 32'd1 : 32'd0;
        end else begin
            cfg_cmd.data = words_q[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            words_q <= cfg_words;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            issue_q <= 1'b0;
            region  <= MAIN;
            addr    <= '0;
            count   <= '0;
            idx     <= '0;
        end else begin
            issue_q <= 1'b0;
            if (walk_start) begin
                active  <= 1'b1;
                issue_q <= 1'b1;
                region  <= MAIN;
                addr    <= `SEQ_CON_BASE;
                count   <= reg_idx_t'(`SEQ_REGS_CON - 1);
                idx     <= '0;
            end else if (active && wr_accepted) begin
                idx <= idx + 1'b1;
                if (last_write) begin
                    active <= 1'b0;
                end else begin
                    issue_q <= 1'b1;
                    if (count == '0) begin
                        // Jump to the next region base
                        case (region)
                            MAIN: begin
                                region <= ACT;
                                addr   <= `SEQ_ACT_BASE;
                                count  <= reg_idx_t'(`SEQ_REGS_ACT - 1);
                            end
                            ACT: begin
                                region <= WEI;
                                addr   <= `SEQ_WEI_BASE;
                                count  <= reg_idx_t'(`SEQ_REGS_WEI - 1);
                            end
                            WEI: begin
                                region <= OUT;
                                addr   <= `SEQ_OUT_BASE;
                                count  <= reg_idx_t'(`SEQ_REGS_OUT - 1);
                            end
                            default: begin
                                region <= INTR;
                                addr   <= `SEQ_INTR_EN_OFFSET;
                                count  <= reg_idx_t'(2);
                            end
                        endcase
                    end else begin
                        addr  <= addr + 13'd4;
                        count <= count - 1'b1;
                    end
                end
            end
        end
    end

    // Next command only after an acceptance, never back to back
    a_issue_single_cycle: assert property (@(posedge clk) disable iff (rst)
        cfg_cmd.issue |=> !cfg_cmd.issue)
        else $error("walker issue held for two cycles");

endmodule

// File: logic/launch_fsm.sv
// ===================================================================
// Sequence controller
// Runs the config walk, waits for all responses, writes the launch word
// Clears the accelerator interrupt after a real launch
// Done pulse and idle-time interrupt forwarding
// ===================================================================

`timescale 1ns/1ps

`include "sauria_seq_config.svh"

module launch_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fsm_start,
    input  logic                      irq_in,
    input  logic                      wr_accepted,
    input  logic                      resp_idle,
    input  logic                      walk_done,
    input  sauria_seq_pkg::seq_mode_t mode,
    input  sauria_seq_pkg::wr_cmd_t   cfg_cmd,
    output logic                      walk_start,
    output logic                      fsm_done,
    output logic                      fwd_irq,
    output sauria_seq_pkg::wr_cmd_t   port_cmd
);

    import sauria_seq_pkg::*;

    seq_state_e state;
    seq_mode_t  mode_q;
    logic       acked;
    logic       resp_back;
    word_t      launch_word;

    assign walk_start = (state == IDLE) && fsm_start;
    assign fsm_done   = (state == DONE);
    assign fwd_irq    = (state == IDLE) && irq_in;

    // Own write has been accepted and its response has drained
    assign resp_back = acked && resp_idle;

    always_comb begin
        launch_word                  = '0;
        launch_word[`SEQ_START_BIT]  = !mode_q.no_start;
        launch_word[`SEQ_ENABLE_BIT] = 1'b1;
        launch_word[`SEQ_SWAP_BIT]   = 1'b1;
        launch_word[`SEQ_KEEP_A_BIT] = mode_q.keep_a;
        launch_word[`SEQ_KEEP_B_BIT] = mode_q.keep_b;
        launch_word[`SEQ_KEEP_C_BIT] = mode_q.keep_c && !mode_q.no_start;
    end

    always_comb begin
        port_cmd = '0;
        case (state)
            WALK: port_cmd = cfg_cmd;
            LAUNCH: begin
                port_cmd.issue = 1'b1;
                port_cmd.addr  = `SEQ_CTRL_OFFSET;
                port_cmd.data  = launch_word;
            end
            CLEAR: begin
                port_cmd.issue = 1'b1;
                port_cmd.addr  = `SEQ_INTR_STATUS_OFFSET;
                port_cmd.data  = 32'd1;
            end
            default: port_cmd = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            mode_q <= mode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            acked <= 1'b0;
        end else begin
            if (wr_accepted) begin
                acked <= 1'b1;
            end else if (port_cmd.issue) begin
                acked <= 1'b0;
            end

            case (state)
                IDLE:        if (fsm_start) state <= WALK;
                WALK:        if (walk_done) state <= SYNC_RESP;
                SYNC_RESP:   if (resp_idle) state <= LAUNCH;
                LAUNCH:      state <= LAUNCH_RESP;
                LAUNCH_RESP: begin
                    if (resp_back) begin
                        state <= mode_q.no_start ? DONE : WAIT_IRQ;
                    end
                end
                WAIT_IRQ:    if (irq_in) state <= CLEAR;
                CLEAR:       state <= CLEAR_RESP;
                CLEAR_RESP:  if (resp_back) state <= DONE;
                DONE:        state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // Every write response is back when done pulses
    a_done_resp_idle: assert property (@(posedge clk) disable iff (rst)
        fsm_done |-> resp_idle)
        else $error("fsm_done with write responses outstanding");

endmodule

// File: logic/sauria_seq_top.sv
// ===================================================================
// Configuration sequencer top level
// Sequence controller, config walker and AXI4-Lite write port
// ===================================================================

`timescale 1ns/1ps

`include "sauria_seq_config.svh"

module sauria_seq_top (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          fsm_start,
    output logic                                          fsm_done,
    input  logic                                          irq_in,
    output logic                                          fwd_irq,
    input  sauria_seq_pkg::seq_mode_t                     mode,
    input  sauria_seq_pkg::word_t [`SEQ_N_CFG_REGS-1:0] cfg_words,
    output sauria_seq_pkg::axil_wr_req_t                  axil_req,
    input  sauria_seq_pkg::axil_wr_rsp_t                  axil_rsp
);

    import sauria_seq_pkg::*;

    wr_cmd_t cfg_cmd;
    wr_cmd_t port_cmd;
    logic    walk_start;
    logic    walk_done;
    logic    wr_accepted;
    logic    resp_idle;

    launch_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .fsm_start  (fsm_start),
        .irq_in     (irq_in),
        .wr_accepted(wr_accepted),
        .resp_idle  (resp_idle),
        .walk_done  (walk_done),
        .mode       (mode),
        .cfg_cmd    (cfg_cmd),
        .walk_start (walk_start),
        .fsm_done   (fsm_done),
        .fwd_irq    (fwd_irq),
        .port_cmd   (port_cmd)
    );

    cfg_write_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .walk_start (walk_start),
        .wr_accepted(wr_accepted),
        .cfg_words  (cfg_words),
        .cfg_cmd    (cfg_cmd),
        .walk_done  (walk_done)
    );

    axil_write_port u_port (
        .clk        (clk),
        .rst        (rst),
        .cmd        (port_cmd),
        .rsp        (axil_rsp),
        .req        (axil_req),
        .wr_accepted(wr_accepted),
        .resp_idle  (resp_idle)
    );

endmodule

// File: bench/axil_target_model.sv
// ===================================================================
// AXI4-Lite write target model
// Random AW/W ready and B response delays of 0 to 3 cycles
// Log of every accepted write, flag for a launch with responses open
// ===================================================================

`timescale 1ns/1ps

`include "sauria_seq_config.svh"

module axil_target_model #(
    parameter int SEED = 77
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         clear_log,
    input  sauria_seq_pkg::axil_wr_req_t req,
    output sauria_seq_pkg::axil_wr_rsp_t rsp
);

    import sauria_seq_pkg::*;

    localparam int MAX_LOG = 32;

    logic [31:0] log_addr [MAX_LOG];
    word_t       log_data [MAX_LOG];
    int          n_writes;
    logic        early_launch;

    int          aw_wait;
    int          w_wait;
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr_q;
    word_t       w_data_q;
    // Remaining delay of each response still owed
    int          b_delay [$];

    initial begin
        int pending;
        void'($urandom(SEED));
        rsp          = '0;
        n_writes     = 0;
        early_launch = 1'b0;
        aw_got       = 1'b0;
        w_got        = 1'b0;
        aw_wait      = $urandom % 4;
        w_wait       = $urandom % 4;
        forever begin
            @(posedge clk);
            if (rst) begin
                aw_got       = 1'b0;
                w_got        = 1'b0;
                n_writes     = 0;
                early_launch = 1'b0;
                b_delay.delete();
            end else begin
                if (clear_log) begin
                    n_writes     = 0;
                    early_launch = 1'b0;
                end
                pending = b_delay.size();
                if (rsp.bvalid && req.bready) begin
                    void'(b_delay.pop_front());
                end else if (pending > 0 && b_delay[0] > 0) begin
                    b_delay[0] = b_delay[0] - 1;
                end
                if (req.awvalid && rsp.awready) begin
                    aw_addr_q = req.awaddr;
                    aw_got    = 1'b1;
                    aw_wait   = $urandom % 4;
                end else if (req.awvalid && aw_wait > 0) begin
                    aw_wait = aw_wait - 1;
                end
                if (req.wvalid && rsp.wready) begin
                    w_data_q = req.wdata;
                    w_got    = 1'b1;
                    w_wait   = $urandom % 4;
                end else if (req.wvalid && w_wait > 0) begin
                    w_wait = w_wait - 1;
                end
                if (aw_got && w_got) begin
                    // Launch must only come once every response is back
                    if (aw_addr_q == 32'(`SEQ_CTRL_OFFSET) && pending != 0) begin
                        early_launch = 1'b1;
                    end
                    if (n_writes < MAX_LOG) begin
                        log_addr[n_writes] = aw_addr_q;
                        log_data[n_writes] = w_data_q;
                    end
                    n_writes = n_writes + 1;
                    b_delay.push_back($urandom % 4);
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                end
            end
            #1;
            rsp.awready = (aw_wait == 0);
            rsp.wready  = (w_wait == 0);
            rsp.bvalid  = (b_delay.size() > 0) && (b_delay[0] == 0);
        end
    end

endmodule

// File: bench/tb_sauria_seq.sv
// ===================================================================
// Testbench of the configuration sequencer
// Clock, reset, stimulus table applied row by row
// Expected write list, per-row checks, cycle limit
// ===================================================================

`timescale 1ns/1ps

`include "sauria_seq_config.svh"

module tb_sauria_seq;

    import sauria_seq_pkg::*;

    localparam int N_ROWS     = 5;
    localparam int N_CFG      = `SEQ_N_CFG_REGS;
    localparam int N_WALK     = N_CFG + 3;
    localparam int MAX_EXP    = N_WALK + 2;
    localparam int MAX_CYCLES = 400 * N_ROWS;

    logic              clk;
    logic              rst;
    logic              fsm_start;
    logic              fsm_done;
    logic              irq_in;
    logic              fwd_irq;
    logic              clear_log;
    logic              running;
    seq_mode_t         mode;
    word_t [N_CFG-1:0] cfg_words;
    axil_wr_req_t      axil_req;
    axil_wr_rsp_t      axil_rsp;

    // Mode bits are {no_start, keep_a, keep_b, keep_c}
    seq_mode_t mode_tbl    [N_ROWS] = '{4'b1101, 4'b0011, 4'b0111, 4'b1000, 4'b0000};
    word_t     pattern_tbl [N_ROWS] = '{32'hA500_0000, 32'h1234_0000, 32'hDEAD_0000,
                                        32'h0000_0100, 32'hFFFF_FFF8};
    int        irq_dly_tbl [N_ROWS] = '{0, 5, 0, 3, 12};

    logic [31:0] exp_addr [MAX_EXP];
    word_t       exp_data [MAX_EXP];
    int          n_exp;
    int          row_errs;
    int          pass_rows;
    int          fail_rows;
    int          done_cnt;
    int          resp_cnt;
    int          resp_at_done;
    int          cycles;

    sauria_seq_top UUT (
        .clk      (clk),
        .rst      (rst),
        .fsm_start(fsm_start),
        .fsm_done (fsm_done),
        .irq_in   (irq_in),
        .fwd_irq  (fwd_irq),
        .mode     (mode),
        .cfg_words(cfg_words),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    axil_target_model #(.SEED(77)) tgt (
        .clk      (clk),
        .rst      (rst),
        .clear_log(clear_log),
        .req      (axil_req),
        .rsp      (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: sequence did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Done pulses, B responses and forwarded interrupt during a run
    initial begin
        done_cnt     = 0;
        resp_cnt     = 0;
        resp_at_done = 0;
        forever begin
            @(posedge clk);
            if (fsm_done === 1'b1) begin
                done_cnt++;
                // Responses of earlier cycles only
                resp_at_done = resp_cnt;
            end
            if (axil_rsp.bvalid === 1'b1 && axil_req.bready === 1'b1) begin
                resp_cnt++;
            end
            if (running && fwd_irq !== 1'b0) begin
                report_failure("fwd_irq went high while the sequencer was busy");
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        row_errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        row_errs++;
    endtask

    task automatic build_expected(input int row);
        logic [31:0] base [4];
        int          cnt  [4];
        seq_mode_t   m;
        word_t       lw;
        int          n;
        int          r;
        int          k;
        base[0] = 32'(`SEQ_CON_BASE);
        base[1] = 32'(`SEQ_ACT_BASE);
        base[2] = 32'(`SEQ_WEI_BASE);
        base[3] = 32'(`SEQ_OUT_BASE);
        cnt[0]  = `SEQ_REGS_CON;
        cnt[1]  = `SEQ_REGS_ACT;
        cnt[2]  = `SEQ_REGS_WEI;
        cnt[3]  = `SEQ_REGS_OUT;
        m       = mode_tbl[row];
        n       = 0;
        for (r = 0; r < 4; r++) begin
            for (k = 0; k < cnt[r]; k++) begin
                exp_addr[n] = base[r] + 32'(4 * k);
                exp_data[n] = pattern_tbl[row] + 32'(n);
                n++;
            end
        end
        // Interrupt enables, then status cleared
        exp_addr[n]   = 32'(`SEQ_INTR_EN_OFFSET);
        exp_data[n]   = 32'd1;
        exp_addr[n+1] = 32'(`SEQ_INTR_EN_OFFSET) + 32'd4;
        exp_data[n+1] = 32'd1;
        exp_addr[n+2] = 32'(`SEQ_INTR_STATUS_OFFSET);
        exp_data[n+2] = 32'd0;
        n = n + 3;
        lw                  = '0;
        lw[`SEQ_START_BIT]  = ~m.no_start;
        lw[`SEQ_ENABLE_BIT] = 1'b1;
        lw[`SEQ_SWAP_BIT]   = 1'b1;
        lw[`SEQ_KEEP_A_BIT] = m.keep_a;
        lw[`SEQ_KEEP_B_BIT] = m.keep_b;
        lw[`SEQ_KEEP_C_BIT] = m.keep_c & ~m.no_start;
        exp_addr[n] = 32'(`SEQ_CTRL_OFFSET);
        exp_data[n] = lw;
        n++;
        if (!m.no_start) begin
            exp_addr[n] = 32'(`SEQ_INTR_STATUS_OFFSET);
            exp_data[n] = 32'd1;
            n++;
        end
        n_exp = n;
    endtask

    task automatic check_writes();
        int i;
        if (tgt.n_writes != n_exp) begin
            report_mismatch("write count", 32'(tgt.n_writes), 32'(n_exp));
        end
        for (i = 0; i < n_exp && i < tgt.n_writes; i++) begin
            if (tgt.log_addr[i] !== exp_addr[i]) begin
                report_mismatch($sformatf("write %0d address", i), tgt.log_addr[i], exp_addr[i]);
            end
            if (tgt.log_data[i] !== exp_data[i]) begin
                report_mismatch($sformatf("write %0d data", i), tgt.log_data[i], exp_data[i]);
            end
        end
        if (tgt.early_launch) begin
            report_failure("launch write accepted before all config responses returned");
        end
    endtask

    task automatic run_row(input int row);
        int done_before;
        int resp_before;
        int i;
        row_errs = 0;
        build_expected(row);
        mode = mode_tbl[row];
        for (i = 0; i < N_CFG; i++) begin
            cfg_words[i] = pattern_tbl[row] + 32'(i);
        end
        clear_log = 1'b1;
        irq_in    = 1'b1;
        next_cycle();
        clear_log = 1'b0;
        if (fwd_irq !== 1'b1) begin
            report_mismatch("fwd_irq while idle", 32'(fwd_irq), 32'd1);
        end
        irq_in = 1'b0;
        next_cycle();
        if (fwd_irq !== 1'b0) begin
            report_mismatch("fwd_irq while idle", 32'(fwd_irq), 32'd0);
        end
        done_before = done_cnt;
        resp_before = resp_cnt;
        fsm_start   = 1'b1;
        running     = 1'b1;
        next_cycle();
        fsm_start = 1'b0;
        if (!mode.no_start) begin
            // Hold the interrupt back until the launch write is in
            while (tgt.n_writes < N_WALK + 1) begin
                next_cycle();
            end
            repeat (irq_dly_tbl[row]) next_cycle();
            if (tgt.n_writes != N_WALK + 1) begin
                report_mismatch("writes before irq_in", 32'(tgt.n_writes), 32'(N_WALK + 1));
            end
            if (done_cnt != done_before) begin
                report_failure("fsm_done came before irq_in was raised");
            end
            irq_in = 1'b1;
        end
        while (done_cnt == done_before) begin
            next_cycle();
        end
        running = 1'b0;
        irq_in  = 1'b0;
        repeat (3) next_cycle();
        if (done_cnt - done_before != 1) begin
            report_mismatch("fsm_done cycles", 32'(done_cnt - done_before), 32'd1);
        end
        // The last response must be in before done pulses
        if (resp_at_done - resp_before != n_exp) begin
            report_mismatch("responses before fsm_done",
                            32'(resp_at_done - resp_before), 32'(n_exp));
        end
        check_writes();
        $display("Row %0d %s: %0d writes, %0d errors", row,
                 (row_errs == 0) ? "ok" : "bad", tgt.n_writes, row_errs);
        if (row_errs == 0) begin
            pass_rows++;
        end else begin
            fail_rows++;
        end
    endtask

    initial begin
        int row;
        rst       = 1'b1;
        fsm_start = 1'b0;
        irq_in    = 1'b0;
        clear_log = 1'b0;
        running   = 1'b0;
        mode      = '0;
        cfg_words = '0;
        pass_rows = 0;
        fail_rows = 0;
        row_errs  = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        for (row = 0; row < N_ROWS; row++) begin
            run_row(row);
        end
        $display("Rows run: %0d, passed: %0d, failed: %0d", N_ROWS, pass_rows, fail_rows);
        if (fail_rows == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sauria_seq.f
+incdir+logic
logic/sauria_seq_pkg.sv
logic/axil_write_port.sv
logic/cfg_write_walker.sv
logic/launch_fsm.sv
logic/sauria_seq_top.sv
bench/axil_target_model.sv
bench/tb_sauria_seq.sv

// File: Makefile
# Verilator build and run for the configuration sequencer

TOP       ?= tb_sauria_seq
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sauria_seq.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_DIR)/V$(TOP)

$(SIM_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(SIM_DIR)

run: build
	./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR) $(LOG)
